// ==== tb.f ====
rtl/memGeometryPkg.sv
rtl/memAccessPkg.sv
rtl/accessDecode.sv
rtl/byteLaneRam.sv
rtl/loadFormat.sv
rtl/memSubsystem.sv
dv/memSubsystemTb.sv

// ==== dv/memSubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
	import memGeometryPkg::*;
	import memAccessPkg::*;

	localparam int clkHalf = 5;                 // 10 ns clock period.
	localparam int driveDelay = 1;              // Inputs change 1 ns after the edge.
	localparam int resetCycles = 10;
	localparam int cyclesPerRow = 8;            // Watchdog budget for one table row.
	localparam int maxRows = 40;
	localparam logic doRead = 1'b1;
	localparam logic doWrite = 1'b0;

	logic CLK;
	logic rstN;
	logic mov;
	logic readWrite;
	memSize_t memSize;
	logic [addrWidth-1:0] extAddress;
	word_t dataIn;
	logic mocOff;
	logic moc;
	word_t dataOut;
	logic sizeError;

	logic rowRead [maxRows];                    // Stimulus columns.
	memSize_t rowSize [maxRows];
	logic [addrWidth-1:0] rowAddr [maxRows];
	word_t rowData [maxRows];
	int rowHold [maxRows];                      // Extra cycles before mocOff.
	logic rowErr [maxRows];                     // Expected sizeError.
	int rowCount;
	integer seed;
	logic [byteWidth-1:0] shadow [memBytes];    // Reference copy of storage, byte per address.

	memSubsystem dut (
		.CLK(CLK),
		.rstN(rstN),
		.mov(mov),
		.readWrite(readWrite),
		.memSize(memSize),
		.extAddress(extAddress),
		.dataIn(dataIn),
		.mocOff(mocOff),
		.moc(moc),
		.dataOut(dataOut),
		.sizeError(sizeError)
	);

	initial begin
		CLK = 1'b0;
		forever #clkHalf CLK = ~CLK;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first failure.");
	endtask

	task automatic checkWord(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			failRun($sformatf("[ERROR] time %0t %s expected 0x%08h actual 0x%08h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			failRun($sformatf("[ERROR] time %0t %s expected %b actual %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic addRow(input logic rd, input memSize_t size, input logic [addrWidth-1:0] addr,
		input word_t setBits, input int hold, input logic err);
		rowRead[rowCount] = rd;
		rowSize[rowCount] = size;
		rowAddr[rowCount] = addr;
		rowData[rowCount] = $random(seed) | setBits;    // Forced bits make sign tests certain.
		rowHold[rowCount] = hold;
		rowErr[rowCount] = err;
		rowCount++;
	endtask

	// Wrap to 256 bytes, then clear the bits that break alignment.
	function automatic int alignedAddr(input memSize_t size, input logic [addrWidth-1:0] addr);
		int a;
		a = int'(addr % memBytes);
		case (size)
			sizeHalf, sizeHalfS: a = a - (a % 2);
			sizeWord: a = a - (a % 4);
			default: a = a;
		endcase
		return a;
	endfunction

	function automatic word_t loadFromShadow(input memSize_t size, input int a);
		word_t v;
		case (size)
			sizeByte: v = {24'b0, shadow[a]};
			sizeByteS: v = {{24{shadow[a][7]}}, shadow[a]};
			sizeHalf: v = {16'b0, shadow[a], shadow[a+1]};      // Lower address is the high byte.
			sizeHalfS: v = {{16{shadow[a][7]}}, shadow[a], shadow[a+1]};
			sizeWord: v = {shadow[a], shadow[a+1], shadow[a+2], shadow[a+3]};
			default: v = '0;
		endcase
		return v;
	endfunction

	task automatic storeToShadow(input memSize_t size, input int a, input word_t data);
		case (size)
			sizeByte, sizeByteS: shadow[a] = data[7:0];
			sizeHalf, sizeHalfS: begin
				shadow[a] = data[15:8];
				shadow[a+1] = data[7:0];
			end
			sizeWord: begin
				shadow[a] = data[31:24];
				shadow[a+1] = data[23:16];
				shadow[a+2] = data[15:8];
				shadow[a+3] = data[7:0];
			end
			default: ;
		endcase
	endtask

	// One full handshake, entered and left 1 ns after a rising edge.
	task automatic runRow(input int i);
		int a;
		word_t expData;
		a = alignedAddr(rowSize[i], rowAddr[i]);
		expData = (rowRead[i] && !rowErr[i]) ? loadFromShadow(rowSize[i], a) : '0;
		mov = 1'b1;
		readWrite = rowRead[i];
		memSize = rowSize[i];
		extAddress = rowAddr[i];
		dataIn = rowData[i];
		@(posedge CLK);                                 // Acceptance edge.
		#driveDelay;
		mov = 1'b0;
		checkFlag("moc", 1'b0, moc);
		for (int c = 1; c <= 3; c++) begin
			@(posedge CLK);
			#driveDelay;
			checkFlag("moc", c == 3, moc);              // Fixed three-cycle latency.
		end
		checkWord("dataOut", expData, dataOut);
		checkFlag("sizeError", rowErr[i], sizeError);
		if (rowHold[i] > 0) begin
			mov = 1'b1;                                 // Stray store, refused while moc is high.
			readWrite = doWrite;
		end
		repeat (rowHold[i]) begin
			@(posedge CLK);
			#driveDelay;
			checkFlag("moc", 1'b1, moc);                // Held while mocOff stays low.
			checkWord("dataOut", expData, dataOut);
			checkFlag("sizeError", rowErr[i], sizeError);
		end
		mocOff = 1'b1;
		mov = 1'b0;
		@(posedge CLK);
		#driveDelay;
		mocOff = 1'b0;
		checkFlag("moc", 1'b0, moc);
		if (!rowRead[i] && !rowErr[i]) begin
			storeToShadow(rowSize[i], a, rowData[i]);   // Reserved codes leave memory alone.
		end
	endtask

	initial begin
		#driveDelay;                                    // Table is built by then.
		repeat (rowCount * cyclesPerRow + resetCycles + 4) @(posedge CLK);
		failRun("Timeout: the test sequence did not finish before the watchdog expired.");
	end

	initial begin
		rstN = 1'b0;
		mov = 1'b0;
		readWrite = 1'b0;
		memSize = sizeByte;
		extAddress = '0;
		dataIn = '0;
		mocOff = 1'b0;
		rowCount = 0;
		seed = 32'haf05;
		addRow(doWrite, sizeWord, 32'h10, '0, 0, 1'b0);         // Bytes come back MSB first.
		addRow(doRead, sizeByte, 32'h10, '0, 0, 1'b0);
		addRow(doRead, sizeByte, 32'h11, '0, 0, 1'b0);
		addRow(doRead, sizeByte, 32'h12, '0, 0, 1'b0);
		addRow(doRead, sizeByte, 32'h13, '0, 0, 1'b0);
		addRow(doRead, sizeHalf, 32'h10, '0, 0, 1'b0);
		addRow(doRead, sizeHalf, 32'h12, '0, 0, 1'b0);
		addRow(doRead, sizeWord, 32'h10, '0, 0, 1'b0);
		addRow(doWrite, sizeWord, 32'h23, '0, 0, 1'b0);         // Lands on 0x20.
		addRow(doRead, sizeWord, 32'h22, '0, 0, 1'b0);
		addRow(doRead, sizeHalf, 32'h21, '0, 0, 1'b0);
		addRow(doRead, sizeHalf, 32'h323, '0, 0, 1'b0);         // Wraps to 0x22.
		addRow(doWrite, sizeByte, 32'h1ff, '0, 0, 1'b0);        // Wraps to 0xff.
		addRow(doRead, sizeByte, 32'hff, '0, 0, 1'b0);
		addRow(doWrite, sizeHalf, 32'habcd0013, '0, 0, 1'b0);   // Lands on 0x12.
		addRow(doRead, sizeWord, 32'h110, '0, 0, 1'b0);
		addRow(doWrite, sizeWord, 32'h30, 32'h80808080, 0, 1'b0); // Every byte negative.
		addRow(doRead, sizeByteS, 32'h30, '0, 0, 1'b0);
		addRow(doRead, sizeByteS, 32'h33, '0, 0, 1'b0);
		addRow(doRead, sizeByte, 32'h31, '0, 0, 1'b0);
		addRow(doRead, sizeHalfS, 32'h30, '0, 0, 1'b0);
		addRow(doRead, sizeHalfS, 32'h33, '0, 0, 1'b0);
		addRow(doRead, sizeHalf, 32'h32, '0, 0, 1'b0);
		addRow(doWrite, sizeWord, 32'h40, '0, 0, 1'b0);         // Partial stores on a word.
		addRow(doWrite, sizeByte, 32'h41, '0, 0, 1'b0);
		addRow(doWrite, sizeHalf, 32'h42, '0, 0, 1'b0);
		addRow(doRead, sizeWord, 32'h40, '0, 2, 1'b0);
		addRow(doWrite, sizeWord, 32'h50, '0, 0, 1'b0);
		addRow(doWrite, 3'b011, 32'h50, '0, 0, 1'b1);           // Reserved, no store.
		addRow(doRead, sizeWord, 32'h50, '0, 0, 1'b0);
		addRow(doRead, 3'b110, 32'h51, '0, 5, 1'b1);            // Back-pressure on an error.
		addRow(doWrite, 3'b111, 32'h52, '0, 0, 1'b1);
		addRow(doRead, sizeWord, 32'h50, '0, 4, 1'b0);
		repeat (resetCycles) @(posedge CLK);
		#driveDelay;
		rstN = 1'b1;
		checkFlag("moc", 1'b0, moc);                            // Clean state before any request.
		checkFlag("sizeError", 1'b0, sizeError);
		checkWord("dataOut", '0, dataOut);
		for (int i = 0; i < rowCount; i++) begin
			runRow(i);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic mov,
	input wire logic readWrite,
	input wire memAccessPkg::memSize_t memSize,
	input wire logic [memGeometryPkg::addrWidth-1:0] extAddress,
	input wire memGeometryPkg::word_t dataIn,
	input wire logic mocOff,
	output logic moc,
	output memGeometryPkg::word_t dataOut,
	output logic sizeError
);
	import memGeometryPkg::*;
	import memAccessPkg::*;

	logic ramEn;                                // Decode to RAM strobe.
	logic ramWrite;
	byteEn_t ramByteEn;
	bankAddr_t ramBankAddr;
	word_t ramWriteData;
	word_t ramReadData;                         // RAM to formatter.
	logic opStrobe;                             // Decode to formatter strobe.
	accessWidth_t opWidth;
	logic opSigned;
	logic opRead;
	logic [1:0] opLane;
	logic opError;
	logic busy;                                 // Formatter back to decode.

	accessDecode uDecode (
		.CLK(CLK),
		.rstN(rstN),
		.mov(mov),
		.readWrite(readWrite),
		.memSize(memSize),
		.extAddress(extAddress),
		.dataIn(dataIn),
		.busy(busy),
		.ramEn(ramEn),
		.ramWrite(ramWrite),
		.ramByteEn(ramByteEn),
		.ramBankAddr(ramBankAddr),
		.ramWriteData(ramWriteData),
		.opStrobe(opStrobe),
		.opWidth(opWidth),
		.opSigned(opSigned),
		.opRead(opRead),
		.opLane(opLane),
		.opError(opError)
	);

	byteLaneRam uRam (
		.CLK(CLK),
		.ramEn(ramEn),
		.ramWrite(ramWrite),
		.ramByteEn(ramByteEn),
		.ramBankAddr(ramBankAddr),
		.ramWriteData(ramWriteData),
		.ramReadData(ramReadData)
	);

	loadFormat uFormat (
		.CLK(CLK),
		.rstN(rstN),
		.opStrobe(opStrobe),
		.opWidth(opWidth),
		.opSigned(opSigned),
		.opRead(opRead),
		.opLane(opLane),
		.opError(opError),
		.ramReadData(ramReadData),
		.mocOff(mocOff),
		.moc(moc),
		.dataOut(dataOut),
		.sizeError(sizeError),
		.busy(busy)
	);

endmodule

`default_nettype wire

// ==== rtl/loadFormat.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadFormat (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic opStrobe,
	input wire memAccessPkg::accessWidth_t opWidth,
	input wire logic opSigned,
	input wire logic opRead,
	input wire logic [1:0] opLane,
	input wire logic opError,
	input wire memGeometryPkg::word_t ramReadData,
	input wire logic mocOff,
	output logic moc,
	output memGeometryPkg::word_t dataOut,
	output logic sizeError,
	busy
);
	import memGeometryPkg::*;
	import memAccessPkg::*;

	logic waitData;                             // RAM word arrives this cycle.
	accessWidth_t heldWidth;
	logic heldSigned;
	logic heldRead;
	logic [1:0] heldLane;
	logic heldError;
	logic [byteWidth-1:0] laneByte;
	logic [2*byteWidth-1:0] laneHalf;
	word_t formatted;

	always_ff @(posedge CLK) begin
		if (opStrobe) begin
			heldWidth <= opWidth;
			heldSigned <= opSigned;
			heldRead <= opRead;
			heldLane <= opLane;
			heldError <= opError;
		end
	end

	always_comb begin
		laneByte = ramReadData[byteWidth * (laneCount - 1 - heldLane) +: byteWidth];
		laneHalf = ramReadData[byteWidth * (laneCount - 2 - heldLane) +: 2 * byteWidth];
		case (heldWidth)
			accessByte: formatted = heldSigned ? word_t'($signed(laneByte)) : word_t'(laneByte);
			accessHalf: formatted = heldSigned ? word_t'($signed(laneHalf)) : word_t'(laneHalf);
			accessWord: formatted = ramReadData;        // Passes straight through.
			default: formatted = '0;
		endcase
		if (heldError || !heldRead) begin
			formatted = '0;                             // Stores and errors return zero.
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			waitData <= 1'b0;
			moc <= 1'b0;
			sizeError <= 1'b0;
			dataOut <= '0;
		end else begin
			waitData <= opStrobe;
			if (waitData) begin
				moc <= 1'b1;                            // Fixed latency completion.
				sizeError <= heldError;
				dataOut <= formatted;
			end else if (moc && mocOff) begin
				moc <= 1'b0;                            // Requester took the result.
				sizeError <= 1'b0;
				dataOut <= '0;
			end
		end
	end

	// Busy covers the data wait and the whole completion phase.
	assign busy = waitData || moc;

	// The requester may not acknowledge before completion exists.
	mocRiseClean: assert property (@(posedge CLK) disable iff (!rstN)
		$rose(moc) |-> !$past(mocOff));

endmodule

`default_nettype wire

// ==== rtl/byteLaneRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteLaneRam (
	input wire logic CLK,
	input wire logic ramEn,
	input wire logic ramWrite,
	input wire memAccessPkg::byteEn_t ramByteEn,
	input wire memGeometryPkg::bankAddr_t ramBankAddr,
	input wire memGeometryPkg::word_t ramWriteData,
	output memGeometryPkg::word_t ramReadData
);
	import memGeometryPkg::*;

	// Bank i holds data bits [8i+7:8i], so bank 0 is big-endian lane 3.
	logic [byteWidth-1:0] bank [laneCount][bankDepth];

	always_ff @(posedge CLK) begin
		if (ramEn) begin
			for (int i = 0; i < laneCount; i++) begin
				if (ramWrite && ramByteEn[i]) begin
					bank[i][ramBankAddr] <= ramWriteData[i*byteWidth +: byteWidth];
				end
				ramReadData[i*byteWidth +: byteWidth] <= bank[i][ramBankAddr];  // Old data.
			end
		end
	end

	// A store must touch at least one lane.
	writeHasLane: assert property (@(posedge CLK) (ramEn && ramWrite) |-> (ramByteEn != '0));

endmodule

`default_nettype wire

// ==== rtl/accessDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module accessDecode (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic mov,
	input wire logic readWrite,
	input wire memAccessPkg::memSize_t memSize,
	input wire logic [memGeometryPkg::addrWidth-1:0] extAddress,
	input wire memGeometryPkg::word_t dataIn,
	input wire logic busy,
	output logic ramEn,
	output logic ramWrite,
	output memAccessPkg::byteEn_t ramByteEn,
	output memGeometryPkg::bankAddr_t ramBankAddr,
	output memGeometryPkg::word_t ramWriteData,
	output logic opStrobe,
	output memAccessPkg::accessWidth_t opWidth,
	output logic opSigned,
	output logic opRead,
	output logic [1:0] opLane,
	output logic opError
);
	import memGeometryPkg::*;
	import memAccessPkg::*;

	logic reqHeld;                              // Request captured, strobes go out next.
	logic reqRead;                              // Held direction, 1 is a read.
	memSize_t reqSize;                          // Held size code.
	logic [bankAddrWidth+1:0] reqAddr;          // Held byte address, upper bits dropped.
	word_t reqData;                             // Held store data.
	logic accept;
	accessWidth_t decWidth;
	logic decError;
	logic [1:0] decLane;
	byteEn_t decByteEn;
	word_t decWriteData;

	// Idle means nothing held, nothing strobed, and the formatter is free.
	assign accept = mov && !reqHeld && !ramEn && !busy;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			reqHeld <= 1'b0;
		end else begin
			reqHeld <= accept;                  // High for the one cycle after acceptance.
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			reqRead <= readWrite;
			reqSize <= memSize;
			reqAddr <= extAddress[bankAddrWidth+1:0];   // Wraps at 256 bytes.
			reqData <= dataIn;
		end
	end

	always_comb begin
		decError = 1'b0;
		decWidth = accessByte;
		decLane = reqAddr[1:0];
		decByteEn = '0;
		decWriteData = '0;
		case (reqSize)
			sizeByte, sizeByteS: begin
				decByteEn = byteEn_t'(4'b1000) >> decLane;  // Lane 0 is the top byte.
				decWriteData = word_t'(reqData[byteWidth-1:0])
					<< (byteWidth * (laneCount - 1 - decLane));
			end
			sizeHalf, sizeHalfS: begin
				decWidth = accessHalf;
				decLane = {reqAddr[1], 1'b0};               // Even lane only.
				decByteEn = byteEn_t'(4'b1100) >> decLane;
				decWriteData = word_t'(reqData[2*byteWidth-1:0])
					<< (byteWidth * (laneCount - 2 - decLane));
			end
			sizeWord: begin
				decWidth = accessWord;
				decLane = 2'b00;                            // Word aligned.
				decByteEn = '1;
				decWriteData = reqData;                     // Already in big-endian order.
			end
			default: begin
				decError = 1'b1;                            // Reserved code, no lanes.
			end
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			ramEn <= 1'b0;
			ramWrite <= 1'b0;
			opStrobe <= 1'b0;
			opError <= 1'b0;
		end else begin
			ramEn <= reqHeld;                               // RAM always reads the row.
			ramWrite <= reqHeld && !reqRead && !decError;   // Reserved codes store nothing.
			opStrobe <= reqHeld;
			opError <= reqHeld && decError;
		end
	end

	always_ff @(posedge CLK) begin
		if (reqHeld) begin
			ramByteEn <= decByteEn;
			ramBankAddr <= reqAddr[bankAddrWidth+1:2];      // Lane bits masked off.
			ramWriteData <= decWriteData;
			opWidth <= decWidth;
			opSigned <= reqSize[2];
			opRead <= reqRead;
			opLane <= decLane;
		end
	end

	// One operation in flight, so the strobe never repeats back to back.
	ramEnSingle: assert property (@(posedge CLK) disable iff (!rstN) ramEn |=> !ramEn);

	noWriteOnError: assert property (@(posedge CLK) disable iff (!rstN)
		!(ramWrite && opError));

endmodule

`default_nettype wire

// ==== rtl/memAccessPkg.sv ====
`default_nettype none

package memAccessPkg;

	// Three-bit size code, bit 2 selects sign extension on loads.
	typedef logic [2:0] memSize_t;

	localparam memSize_t sizeByte = 3'b000;     // Unsigned byte.
	localparam memSize_t sizeHalf = 3'b001;     // Unsigned halfword.
	localparam memSize_t sizeWord = 3'b010;     // Full word.
	localparam memSize_t sizeByteS = 3'b100;    // Signed byte.
	localparam memSize_t sizeHalfS = 3'b101;    // Signed halfword.

	// Decoded access width carried to the formatter.
	typedef enum logic [1:0] {
		accessByte,                             // One lane.
		accessHalf,                             // Two lanes.
		accessWord                              // All four lanes.
	} accessWidth_t;

	// Bit 3 is lane 0, the most significant byte (big endian).
	typedef logic [3:0] byteEn_t;

endpackage

`default_nettype wire

// ==== rtl/memGeometryPkg.sv ====
`default_nettype none

package memGeometryPkg;

	localparam int addrWidth = 32;                      // External address bus width.
	localparam int wordWidth = 32;                      // Data word width.
	localparam int byteWidth = 8;                       // One addressable unit.
	localparam int memBytes = 256;                      // Total storage in bytes.
	localparam int laneCount = wordWidth / byteWidth;   // Byte lanes per word.
	localparam int bankDepth = memBytes / laneCount;    // Entries in each lane bank.
	localparam int bankAddrWidth = $clog2(bankDepth);   // Index width into one bank.

	typedef logic [wordWidth-1:0] word_t;               // Full data word.
	typedef logic [bankAddrWidth-1:0] bankAddr_t;       // Word row inside the banks.

endpackage

`default_nettype wire
